/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= daddaMultiplierTb
FILELIST  ?= daddaMul.f
OBJDIR    ?= obj_dir

SIM = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the simulator exits non-zero when the testbench stops on an error.
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

/* bench/daddaMultiplierTb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "daddaMul_defines.svh"

module daddaMultiplierTb
	import daddaMulPkg::*;
;

	localparam int numCorner = 42;
	localparam int numRandom = 2000;
	localparam int numGap = 300;
	localparam int numFlushed = 3;
	localparam int numAfterReset = 50;
	localparam int numTests = numCorner + numRandom + numGap + numFlushed + numAfterReset;
	localparam int timeoutNs = (numTests + 50) * 4 * 2;

	logic clk;
	logic rstN;
	logic inValid;
	mulReq_t req;
	logic outValid;
	product_t product;

	int cycle = 0;
	product_t expQ[$];
	int issueQ[$]; // cycle in which each request is presented to the DUT.

	daddaMultiplier dut (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.req      (req),
		.outValid (outValid),
		.product  (product)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic product_t refProduct(input operand_t a, input operand_t b);
		return product_t'(a) * product_t'(b);
	endfunction

	task automatic checkValue(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %0h, expected %0h.", $time, what, got, exp);
			$display("Verification failed");
			$fatal(1, "a checked value did not match.");
		end
	endtask

	// inputs change half a nanosecond after the rising edge.
	task automatic stepCycle();
		@(posedge clk);
		#0.5;
	endtask

	task automatic issueWithExpected(input operand_t a, input operand_t b,
			input product_t expected);
		req.a = a;
		req.b = b;
		inValid = 1'b1;
		expQ.push_back(expected);
		issueQ.push_back(cycle);
		stepCycle();
	endtask

	task automatic issue(input operand_t a, input operand_t b);
		issueWithExpected(a, b, refProduct(a, b));
	endtask

	task automatic idleCycle();
		inValid = 1'b0;
		req = mulReq_t'($urandom); // operands are ignored without inValid.
		stepCycle();
	endtask

	task automatic issueRandom();
		issue(operand_t'($urandom), operand_t'($urandom));
	endtask

	task automatic runCorners();
		issue(16'h0000, 16'h1234);
		issue(16'hABCD, 16'h0000);
		issue(16'h0000, 16'hFFFF);
		issue(16'h0001, 16'h5A5A);
		issue(16'hBEEF, 16'h0001);
		issueWithExpected(16'hFFFF, 16'hFFFF, 32'hFFFE_0001);
		for (int i = 0; i < `MUL_WIDTH; i++) begin
			issue(operand_t'(1 << i), operand_t'(1 << (`MUL_WIDTH - 1 - i)));
			issue(operand_t'(1 << i), 16'hFFFF);
		end
		issue(16'hAAAA, 16'h5555);
		issue(16'h5555, 16'hAAAA);
		issue(16'hAAAA, 16'hAAAA);
		issue(16'h5555, 16'h5555);
	endtask

	// Reset lands while several requests are still in the pipeline.
	task automatic resetInFlight();
		repeat (numFlushed)
			issueRandom();
		rstN = 1'b0;
		inValid = 1'b0;
		expQ.delete();
		issueQ.delete();
		repeat (5) begin
			stepCycle();
			checkValue(64'(outValid), 64'd0, "outValid during reset");
		end
		rstN = 1'b1;
		repeat (3) begin
			checkValue(64'(outValid), 64'd0, "outValid after reset release");
			idleCycle();
		end
	endtask

	always @(negedge clk) begin : compareResults
		product_t expected;
		int issued;
		if (outValid) begin
			if (!rstN) begin
				$display("Verification failed");
				$fatal(1, "outValid was high while reset was asserted.");
			end else if (expQ.size() == 0) begin
				$display("Verification failed");
				$fatal(1, "outValid came high with no request outstanding.");
			end else begin
				expected = expQ.pop_front();
				issued = issueQ.pop_front();
				if (cycle - issued != `MUL_LATENCY) begin
					$display("Verification failed");
					$fatal(1, $sformatf("result of the request issued in cycle %0d came at cycle %0d.",
						issued, cycle));
				end else begin
					checkValue(64'(product), 64'(expected),
						$sformatf("product of the request issued in cycle %0d", issued));
				end
			end
		end
	end

	initial begin
		#timeoutNs;
		$display("Verification failed");
		$fatal(1, "the run did not finish in time.");
	end

	initial begin
		int gap;
		void'($urandom(44702));
		clk = 1'b0;
		rstN = 1'b0;
		inValid = 1'b0;
		req = '0;
		repeat (10)
			stepCycle();
		rstN = 1'b1;

		repeat (5) begin
			checkValue(64'(outValid), 64'd0, "outValid before any request");
			idleCycle();
		end

		runCorners();

		repeat (numRandom)
			issueRandom();

		// random idle gaps, so pulses must line up with their own requests.
		repeat (numGap) begin
			issueRandom();
			gap = int'($urandom_range(3, 0));
			repeat (gap)
				idleCycle();
		end

		resetInFlight();

		repeat (numAfterReset)
			issueRandom();

		repeat (`MUL_LATENCY + 2)
			idleCycle();

		if (expQ.size() != 0) begin
			$display("Verification failed");
			$fatal(1, $sformatf("%0d requests never produced a result.", expQ.size()));
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* daddaMul.f */
+incdir+hdl
hdl/daddaMulPkg.sv
hdl/daddaTree.sv
hdl/claAdder.sv
hdl/daddaMultiplier.sv
bench/daddaMultiplierTb.sv

/* hdl/claAdder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "daddaMul_defines.svh"

module claAdder
	import daddaMulPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     csValid,
	input  csPair_t  cs,
	output logic     outValid,
	output product_t product
);

	localparam int numGroups = `PROD_WIDTH / `CLA_GROUP;

	// Carry into bit n of a group, written out as a flat sum of products.
	// Each term is one generate, or the group carry in, passed up by the propagates above it.
	function automatic logic lookahead(input logic [`CLA_GROUP-1:0] gen,
			input logic [`CLA_GROUP-1:0] prop, input logic cin, input int n);
		logic acc;
		logic term;
		acc = 1'b0;
		for (int j = -1; j < n; j++) begin
			if (j < 0)
				term = cin;
			else
				term = gen[j];
			for (int m = j + 1; m < n; m++)
				term = term & prop[m];
			acc = acc | term;
		end
		return acc;
	endfunction

	product_t g;
	product_t p;
	product_t carry;
	product_t sum;
	logic [numGroups-1:0] grpG;
	logic [numGroups-1:0] grpP;
	logic [numGroups:0] grpCarry;

	assign g = cs.sumRow & cs.carryRow;
	assign p = cs.sumRow ^ cs.carryRow;

	always_comb begin
		grpCarry[0] = 1'b0;
		for (int k = 0; k < numGroups; k++) begin
			grpG[k] = lookahead(g[k*`CLA_GROUP +: `CLA_GROUP], p[k*`CLA_GROUP +: `CLA_GROUP],
				1'b0, `CLA_GROUP);
			grpP[k] = &p[k*`CLA_GROUP +: `CLA_GROUP];
			grpCarry[k+1] = grpG[k] | (grpP[k] & grpCarry[k]);
			for (int i = 0; i < `CLA_GROUP; i++)
				carry[k*`CLA_GROUP + i] = lookahead(g[k*`CLA_GROUP +: `CLA_GROUP],
					p[k*`CLA_GROUP +: `CLA_GROUP], grpCarry[k], i);
		end
	end

	assign sum = p ^ carry;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			outValid <= 1'b0;
		else
			outValid <= csValid;
	end

	always_ff @(posedge clk) begin
		if (csValid)
			product <= sum; // the carry out of the top group is always zero.
	end

	// column 0 holds a single partial product, so the tree never leaves a carry there.
	assert property (@(posedge clk) disable iff (!rstN) csValid |-> !cs.carryRow[0])
		else $error("claAdder: carry row bit 0 set by the reduction tree.");

	assert property (@(posedge clk) disable iff (!rstN) csValid |-> !grpCarry[numGroups])
		else $error("claAdder: carry-save rows overflow the product width.");

	assert property (@(posedge clk) disable iff (!rstN) outValid == $past(csValid))
		else $error("claAdder: outValid out of step with csValid.");

endmodule

`default_nettype wire

/* hdl/daddaMulPkg.sv */
`default_nettype none
`include "daddaMul_defines.svh"

package daddaMulPkg;

	typedef logic [`MUL_WIDTH-1:0] operand_t;

	typedef logic [`PROD_WIDTH-1:0] product_t;

	typedef struct packed {
		operand_t a;
		operand_t b;
	} mulReq_t;

	// two rows left after reduction, their sum is the product.
	typedef struct packed {
		product_t sumRow;
		product_t carryRow;
	} csPair_t;

endpackage

`default_nettype wire

/* hdl/daddaMul_defines.svh */
`ifndef DADDAMUL_DEFINES_SVH
`define DADDAMUL_DEFINES_SVH

// width of each unsigned operand.
`define MUL_WIDTH 16

// full product width, two operands side by side.
`define PROD_WIDTH (2 * `MUL_WIDTH)

// bits resolved together by one lookahead group in the final adder.
`define CLA_GROUP 4

// register stages between inValid and outValid.
// one after the reduction tree, one after the final adder.
`define MUL_LATENCY 2

`endif

/* hdl/daddaMultiplier.sv */
`timescale 1ns/100ps
`default_nettype none
`include "daddaMul_defines.svh"

module daddaMultiplier
	import daddaMulPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     inValid,
	input  mulReq_t  req,
	output logic     outValid,
	output product_t product
);

	logic csValid;
	csPair_t cs; // carry-save rows between the two register stages.

	daddaTree tree (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.req     (req),
		.csValid (csValid),
		.cs      (cs)
	);

	claAdder adder (
		.clk      (clk),
		.rstN     (rstN),
		.csValid  (csValid),
		.cs       (cs),
		.outValid (outValid),
		.product  (product)
	);

endmodule

`default_nettype wire

/* hdl/daddaTree.sv */
`timescale 1ns/100ps
`default_nettype none
`include "daddaMul_defines.svh"

module daddaTree
	import daddaMulPkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  logic    inValid,
	input  mulReq_t req,
	output logic    csValid,
	output csPair_t cs
);

	// k-th entry of the Dadda height sequence 2, 3, 4, 6, 9, 13, ...
	function automatic int seqHeight(input int k);
		int d;
		d = 2;
		for (int j = 0; j < k; j++)
			d = d * 3 / 2;
		return d;
	endfunction

	function automatic int countStages();
		int n;
		n = 0;
		while (seqHeight(n) < `MUL_WIDTH)
			n++;
		return n;
	endfunction

	localparam int numStages = countStages();
	localparam int maxHeight = `MUL_WIDTH;

	// stage 0 reduces to the largest height below the operand width.
	function automatic int targetHeight(input int s);
		return seqHeight(numStages - 1 - s);
	endfunction

	function automatic int initHeight(input int c);
		if (c < `MUL_WIDTH)
			return c + 1;
		return 2 * `MUL_WIDTH - 1 - c;
	endfunction

	// Replays the reduction up to stage s and reports one figure for column c.
	// sel 0 gives the height, 1 the full adders, 2 the half adders, 3 the carries in.
	function automatic int stageInfo(input int s, input int c, input int sel);
		logic [8*`PROD_WIDTH-1:0] h;
		int cin;
		int ex;
		int fa;
		int ha;
		int res;
		res = 0;
		for (int col = 0; col < `PROD_WIDTH; col++)
			h[col*8 +: 8] = 8'(initHeight(col));
		for (int st = 0; st <= s; st++) begin
			cin = 0;
			for (int col = 0; col < `PROD_WIDTH; col++) begin
				ex = int'(h[col*8 +: 8]) + cin - targetHeight(st);
				fa = (ex > 0) ? ex / 2 : 0;
				ha = (ex > 0) ? ex % 2 : 0;
				if (st == s && col == c) begin
					case (sel)
						0: res = int'(h[col*8 +: 8]);
						1: res = fa;
						2: res = ha;
						default: res = cin;
					endcase
				end
				h[col*8 +: 8] = 8'(int'(h[col*8 +: 8]) - 2 * fa - ha + cin);
				cin = fa + ha; // carries land in the next column.
			end
		end
		return res;
	endfunction

	logic [maxHeight-1:0] colBits [0:numStages][0:`PROD_WIDTH-1];
	logic [maxHeight-1:0] carryBits [0:numStages-1][0:`PROD_WIDTH-1];
	csPair_t csNext;

	// partial products, stacked from the bottom of each weight column.
	for (genvar c = 0; c < `PROD_WIDTH; c++) begin : gPp
		localparam int height = initHeight(c);
		localparam int firstRow = (c < `MUL_WIDTH) ? 0 : c - `MUL_WIDTH + 1;
		for (genvar k = 0; k < maxHeight; k++) begin : gBit
			if (k < height) begin : gAnd
				assign colBits[0][c][k] = req.a[firstRow + k] & req.b[c - firstRow - k];
			end else begin : gZero
				assign colBits[0][c][k] = 1'b0;
			end
		end
	end

	for (genvar s = 0; s < numStages; s++) begin : gStage
		for (genvar c = 0; c < `PROD_WIDTH; c++) begin : gCol
			localparam int height = stageInfo(s, c, 0);
			localparam int numFa = stageInfo(s, c, 1);
			localparam int numHa = stageInfo(s, c, 2);
			localparam int numCin = stageInfo(s, c, 3);
			localparam int nextHeight = height - 2 * numFa - numHa + numCin;

			for (genvar j = 0; j < numFa; j++) begin : gFa
				logic x;
				logic y;
				logic z;
				assign x = colBits[s][c][3*j];
				assign y = colBits[s][c][3*j + 1];
				assign z = colBits[s][c][3*j + 2];
				assign colBits[s+1][c][j] = x ^ y ^ z;
				assign carryBits[s][c][j] = (x & y) | (x & z) | (y & z);
			end

			if (numHa > 0) begin : gHa
				logic x;
				logic y;
				assign x = colBits[s][c][3*numFa];
				assign y = colBits[s][c][3*numFa + 1];
				assign colBits[s+1][c][numFa] = x ^ y;
				assign carryBits[s][c][numFa] = x & y;
			end

			for (genvar j = 0; j < numCin; j++) begin : gCin
				assign colBits[s+1][c][numFa + numHa + j] = carryBits[s][c-1][j];
			end

			// bits no adder touched move straight on, above the new ones.
			for (genvar k = 3 * numFa + 2 * numHa; k < height; k++) begin : gPass
				assign colBits[s+1][c][k - 2 * numFa - numHa + numCin] = colBits[s][c][k];
			end

			for (genvar k = nextHeight; k < maxHeight; k++) begin : gFill
				assign colBits[s+1][c][k] = 1'b0;
			end

			for (genvar k = numFa + numHa; k < maxHeight; k++) begin : gNoCarry
				assign carryBits[s][c][k] = 1'b0;
			end
		end
	end

	always_comb begin
		for (int c = 0; c < `PROD_WIDTH; c++) begin
			csNext.sumRow[c] = colBits[numStages][c][0];
			csNext.carryRow[c] = colBits[numStages][c][1];
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			csValid <= 1'b0;
		else
			csValid <= inValid;
	end

	always_ff @(posedge clk) begin
		if (inValid)
			cs <= csNext;
	end

	assert property (@(posedge clk) disable iff (!rstN) inValid |-> !$isunknown(req))
		else $error("daddaTree: operand with unknown bits on a valid request.");

endmodule

`default_nettype wire
